// ==== eth_loop_cfg.svh ====
// ----------------------------------------------------------------------
// default sizes for the loopback buffer. Frame FIFO depth must be a
// power of two, and a frame longer than that depth is dropped.
// ----------------------------------------------------------------------
`ifndef ETH_LOOP_CFG_SVH
`define ETH_LOOP_CFG_SVH

// byte entries in the frame FIFO.
`define ETH_LOOP_FRAME_DEPTH 64

// control words in flight.
`define ETH_LOOP_CTL_DEPTH 4

// checksum value and byte position widths.
`define ETH_LOOP_CSUM_W 16
`define ETH_LOOP_CPOS_W 11

`endif

// ==== rtl/eth_loop_pkg.sv ====
// ----------------------------------------------------------------------
// payload types for the loopback buffer. Widths follow the cfg header.
// ----------------------------------------------------------------------
`include "eth_loop_cfg.svh"

package eth_loop_pkg;

	// one buffered byte.
	typedef struct packed {
		logic       fcs_active;
		logic [7:0] data;
	} frame_beat_t;

	// per-frame control word, read on the last input beat.
	typedef struct packed {
		logic                        update_fcs;
		logic [`ETH_LOOP_CSUM_W-1:0] csum_val;
		logic [`ETH_LOOP_CPOS_W-1:0] csum_pos;
		logic                        drop;
		logic                        corrupt;
	} ctl_word_t;

endpackage

// ==== rtl/axis_sync_fifo.sv ====
// ----------------------------------------------------------------------
// single clock FWFT FIFO. DEPTH must be a power of two and at least 2.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module axis_sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 16
) (
	input  logic     clk,
	input  logic     rst_n,

	input  payload_t s_payload,
	input  logic     s_last,
	input  logic     s_valid,
	output logic     s_ready,

	output payload_t m_payload,
	output logic     m_last,
	output logic     m_valid,
	input  logic     m_ready
);
	localparam int AW = $clog2(DEPTH);

	payload_t   mem [DEPTH];
	logic       last_mem [DEPTH];

	// extra msb on each pointer tells full from empty.
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	logic full;
	logic empty;
	logic wr_en;
	logic rd_en;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign s_ready = ~full;
	assign m_valid = ~empty;

	assign wr_en = s_valid & ~full;
	assign rd_en = m_ready & ~empty;

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[AW-1:0]]      <= s_payload;
			last_mem[wr_ptr[AW-1:0]] <= s_last;
		end
	end

	// head of the buffer shows without a read request.
	assign m_payload = mem[rd_ptr[AW-1:0]];
	assign m_last    = last_mem[rd_ptr[AW-1:0]];

endmodule

// ==== rtl/eth_frame_loop_fifo.sv ====
// ----------------------------------------------------------------------
// input has no back-pressure. Frames that find no room are skipped whole,
// and a frame above FRAME_DEPTH bytes is cut and marked for dropping.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "eth_loop_cfg.svh"

module eth_frame_loop_fifo #(
	parameter int FRAME_DEPTH = `ETH_LOOP_FRAME_DEPTH,
	parameter int CTL_DEPTH   = `ETH_LOOP_CTL_DEPTH
) (
	input  logic                        clk,
	input  logic                        rst_n,

	input  logic [7:0]                  s_data,
	input  logic                        s_fcs_active,
	input  logic                        s_update_fcs,
	input  logic [`ETH_LOOP_CSUM_W-1:0] s_csum_val,
	input  logic [`ETH_LOOP_CPOS_W-1:0] s_csum_pos,
	input  logic                        s_drop,
	input  logic                        s_corrupt,
	input  logic                        s_last,
	input  logic                        s_valid,

	output eth_loop_pkg::frame_beat_t   frame_beat,
	output logic                        frame_last,
	output logic                        frame_valid,
	input  logic                        frame_ready,

	output eth_loop_pkg::ctl_word_t     ctl_word,
	output logic                        ctl_valid,
	input  logic                        ctl_ready
);
	localparam int CNT_W = $clog2(FRAME_DEPTH);

	typedef enum logic [2:0] {
		ST_WAIT,
		ST_WRITE_FRAME,
		ST_WRITE_CTL,
		ST_OVF_TERM,
		ST_OVF_CTL
	} state_t;

	state_t state;
	state_t state_next;

	logic in_frame;
	logic [CNT_W-1:0] beat_cnt;

	eth_loop_pkg::frame_beat_t frame_in;
	logic frame_in_last;
	logic frame_in_valid;
	logic frame_in_ready;

	eth_loop_pkg::ctl_word_t ctl_in;
	eth_loop_pkg::ctl_word_t ctl_hold;
	logic ctl_in_valid;
	logic ctl_in_ready;

	logic take_beat;
	logic overflow;

	// a beat that belongs to a frame this block has started.
	assign take_beat = (state == ST_WRITE_FRAME) & s_valid & ~in_frame;

	// keep one slot free so the terminator can always land.
	assign overflow = ~frame_in_ready |
		((beat_cnt == CNT_W'(FRAME_DEPTH - 1)) & ~s_last);

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			state    <= ST_WAIT;
			in_frame <= 1'b0;
			beat_cnt <= '0;
		end else begin
			state <= state_next;

			if (state != ST_WRITE_FRAME) begin
				if (s_valid) begin
					in_frame <= ~s_last;
				end
			end else if (s_valid & s_last) begin
				in_frame <= 1'b0;
			end else if (take_beat & overflow) begin
				in_frame <= 1'b1;
			end

			if (state == ST_WAIT) begin
				beat_cnt <= '0;
			end else if (take_beat & ~overflow) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// control fields are sampled on the last beat.
	always_ff @(posedge clk) begin
		if (take_beat & ~overflow & s_last) begin
			ctl_hold.update_fcs <= s_update_fcs;
			ctl_hold.csum_val   <= s_csum_val;
			ctl_hold.csum_pos   <= s_csum_pos;
			ctl_hold.drop       <= s_drop;
			ctl_hold.corrupt    <= s_corrupt;
		end
	end

	always_comb begin
		state_next = state;

		frame_in.data       = s_data;
		frame_in.fcs_active = s_fcs_active;
		frame_in_last       = s_last;
		frame_in_valid      = 1'b0;

		ctl_in       = ctl_hold;
		ctl_in_valid = 1'b0;

		case (state)
			ST_WAIT: begin
				if (frame_in_ready & ctl_in_ready) begin
					state_next = ST_WRITE_FRAME;
				end
			end

			ST_WRITE_FRAME: begin
				if (take_beat) begin
					if (overflow) begin
						state_next = ST_OVF_TERM;
					end else begin
						frame_in_valid = 1'b1;
						if (s_last) begin
							state_next = ST_WRITE_CTL;
						end
					end
				end
			end

			ST_WRITE_CTL: begin
				ctl_in_valid = 1'b1;
				if (ctl_in_ready) begin
					state_next = ST_WAIT;
				end
			end

			ST_OVF_TERM: begin
				frame_in.data       = 8'h00;
				frame_in.fcs_active = 1'b0;
				frame_in_last       = 1'b1;
				frame_in_valid      = 1'b1;
				if (frame_in_ready) begin
					state_next = ST_OVF_CTL;
				end
			end

			ST_OVF_CTL: begin
				ctl_in       = '0;
				ctl_in.drop  = 1'b1;
				ctl_in_valid = 1'b1;
				if (ctl_in_ready) begin
					state_next = ST_WAIT;
				end
			end

			default: begin
				state_next = ST_WAIT;
			end
		endcase
	end

	axis_sync_fifo #(
		.payload_t(eth_loop_pkg::frame_beat_t),
		.DEPTH    (FRAME_DEPTH)
	) i_frame_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.s_payload(frame_in),
		.s_last   (frame_in_last),
		.s_valid  (frame_in_valid),
		.s_ready  (frame_in_ready),
		.m_payload(frame_beat),
		.m_last   (frame_last),
		.m_valid  (frame_valid),
		.m_ready  (frame_ready)
	);

	axis_sync_fifo #(
		.payload_t(eth_loop_pkg::ctl_word_t),
		.DEPTH    (CTL_DEPTH)
	) i_ctl_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.s_payload(ctl_in),
		.s_last   (1'b0),
		.s_valid  (ctl_in_valid),
		.s_ready  (ctl_in_ready),
		.m_payload(ctl_word),
		.m_last   (),
		.m_valid  (ctl_valid),
		.m_ready  (ctl_ready)
	);

endmodule

// ==== rtl/eth_loop_tx_gate.sv ====
// ----------------------------------------------------------------------
// a control word must only appear once its whole frame is buffered.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "eth_loop_cfg.svh"

module eth_loop_tx_gate (
	input  logic                        clk,
	input  logic                        rst_n,

	input  eth_loop_pkg::frame_beat_t   frame_beat,
	input  logic                        frame_last,
	input  logic                        frame_valid,
	output logic                        frame_ready,

	input  eth_loop_pkg::ctl_word_t     ctl_word,
	input  logic                        ctl_valid,
	output logic                        ctl_ready,

	output logic [7:0]                  tx_data,
	output logic                        tx_fcs_active,
	output logic                        tx_last,
	output logic                        tx_valid,
	input  logic                        tx_ready,

	output logic                        tx_update_fcs,
	output logic [`ETH_LOOP_CSUM_W-1:0] tx_csum_val,
	output logic [`ETH_LOOP_CPOS_W-1:0] tx_csum_pos,
	output logic                        tx_corrupt
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FORWARD,
		ST_DISCARD
	} state_t;

	state_t state;
	state_t state_next;

	logic beat_done;

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next  = state;
		frame_ready = 1'b0;
		tx_valid    = 1'b0;
		beat_done   = 1'b0;

		case (state)
			ST_IDLE: begin
				if (ctl_valid) begin
					state_next = ctl_word.drop ? ST_DISCARD : ST_FORWARD;
				end
			end

			ST_FORWARD: begin
				tx_valid    = frame_valid;
				frame_ready = tx_ready;
				beat_done   = frame_valid & tx_ready;
			end

			// drains one beat per cycle, whatever tx_ready does.
			ST_DISCARD: begin
				frame_ready = 1'b1;
				beat_done   = frame_valid;
			end

			default: begin
				state_next = ST_IDLE;
			end
		endcase

		if (beat_done & frame_last) begin
			state_next = ST_IDLE;
		end
	end

	// control word leaves with the last beat of its frame.
	assign ctl_ready = beat_done & frame_last;

	assign tx_data       = frame_beat.data;
	assign tx_fcs_active = frame_beat.fcs_active;
	assign tx_last       = frame_last;

	// head of the control FIFO holds still for the whole frame.
	assign tx_update_fcs = ctl_word.update_fcs;
	assign tx_csum_val   = ctl_word.csum_val;
	assign tx_csum_pos   = ctl_word.csum_pos;
	assign tx_corrupt    = ctl_word.corrupt;

endmodule

// ==== rtl/eth_loop_top.sv ====
// ----------------------------------------------------------------------
// loopback buffer top. Input has no back-pressure, latency varies.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "eth_loop_cfg.svh"

module eth_loop_top (
	input  logic                        clk,
	input  logic                        rst_n,

	input  logic [7:0]                  s_data,
	input  logic                        s_fcs_active,
	input  logic                        s_update_fcs,
	input  logic [`ETH_LOOP_CSUM_W-1:0] s_csum_val,
	input  logic [`ETH_LOOP_CPOS_W-1:0] s_csum_pos,
	input  logic                        s_drop,
	input  logic                        s_corrupt,
	input  logic                        s_last,
	input  logic                        s_valid,

	output logic [7:0]                  tx_data,
	output logic                        tx_last,
	output logic                        tx_fcs_active,
	output logic                        tx_valid,
	input  logic                        tx_ready,

	output logic                        tx_update_fcs,
	output logic [`ETH_LOOP_CSUM_W-1:0] tx_csum_val,
	output logic [`ETH_LOOP_CPOS_W-1:0] tx_csum_pos,
	output logic                        tx_corrupt
);
	eth_loop_pkg::frame_beat_t frame_beat;
	logic frame_last;
	logic frame_valid;
	logic frame_ready;

	eth_loop_pkg::ctl_word_t ctl_word;
	logic ctl_valid;
	logic ctl_ready;

	eth_frame_loop_fifo #(
		.FRAME_DEPTH(`ETH_LOOP_FRAME_DEPTH),
		.CTL_DEPTH  (`ETH_LOOP_CTL_DEPTH)
	) i_loop (
		.clk         (clk),
		.rst_n       (rst_n),
		.s_data      (s_data),
		.s_fcs_active(s_fcs_active),
		.s_update_fcs(s_update_fcs),
		.s_csum_val  (s_csum_val),
		.s_csum_pos  (s_csum_pos),
		.s_drop      (s_drop),
		.s_corrupt   (s_corrupt),
		.s_last      (s_last),
		.s_valid     (s_valid),
		.frame_beat  (frame_beat),
		.frame_last  (frame_last),
		.frame_valid (frame_valid),
		.frame_ready (frame_ready),
		.ctl_word    (ctl_word),
		.ctl_valid   (ctl_valid),
		.ctl_ready   (ctl_ready)
	);

	eth_loop_tx_gate i_gate (
		.clk          (clk),
		.rst_n        (rst_n),
		.frame_beat   (frame_beat),
		.frame_last   (frame_last),
		.frame_valid  (frame_valid),
		.frame_ready  (frame_ready),
		.ctl_word     (ctl_word),
		.ctl_valid    (ctl_valid),
		.ctl_ready    (ctl_ready),
		.tx_data      (tx_data),
		.tx_fcs_active(tx_fcs_active),
		.tx_last      (tx_last),
		.tx_valid     (tx_valid),
		.tx_ready     (tx_ready),
		.tx_update_fcs(tx_update_fcs),
		.tx_csum_val  (tx_csum_val),
		.tx_csum_pos  (tx_csum_pos),
		.tx_corrupt   (tx_corrupt)
	);

endmodule

// ==== testbench/tb_clk_gen.sv ====
// ----------------------------------------------------------------------
// 40 ns clock, reset low for the first 10 cycles.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// released on a falling edge like the rest of the stimulus.
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== testbench/tb_eth_loop_top.sv ====
// ----------------------------------------------------------------------
// random frames against a queue model. Depths come from the cfg header,
// test 4 assumes a frame FIFO of 64 and test 5 a control FIFO of 4.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "eth_loop_cfg.svh"

module tb_eth_loop_top;
	localparam int CSUM_W      = `ETH_LOOP_CSUM_W;
	localparam int CPOS_W      = `ETH_LOOP_CPOS_W;
	localparam int NUM_FRAMES  = 24;
	localparam int MAX_LEN     = 40;
	localparam int MAX_GAP     = 6;
	localparam int STIM_CYCLES = 3 * NUM_FRAMES * (MAX_LEN + MAX_GAP) + 500;
	localparam int LIMIT       = 4 * STIM_CYCLES + 2000;

	typedef struct packed {
		logic [7:0]        len;
		logic              fcs;
		logic              update_fcs;
		logic [CSUM_W-1:0] csum_val;
		logic [CPOS_W-1:0] csum_pos;
		logic              corrupt;
	} frame_exp_t;

	logic clk;
	logic rst_n;
	logic [7:0] s_data;
	logic s_fcs_active;
	logic s_update_fcs;
	logic [CSUM_W-1:0] s_csum_val;
	logic [CPOS_W-1:0] s_csum_pos;
	logic s_drop;
	logic s_corrupt;
	logic s_last;
	logic s_valid;
	logic [7:0] tx_data;
	logic tx_last;
	logic tx_fcs_active;
	logic tx_valid;
	logic tx_ready;
	logic tx_update_fcs;
	logic [CSUM_W-1:0] tx_csum_val;
	logic [CPOS_W-1:0] tx_csum_pos;
	logic tx_corrupt;

	integer seed;
	int ready_mode;
	int errors;
	int err_mark;
	int pass_cnt;
	int fail_cnt;
	int cycle_cnt;
	int beat_idx;
	logic stalled;
	logic [7:0] held_data;
	logic held_last;
	frame_exp_t exp_frames[$];
	logic [7:0] exp_bytes[$];

	tb_clk_gen i_clk_gen (
		.clk  (clk),
		.rst_n(rst_n)
	);

	eth_loop_top i_dut (
		.clk(clk), .rst_n(rst_n),
		.s_data(s_data), .s_fcs_active(s_fcs_active), .s_update_fcs(s_update_fcs),
		.s_csum_val(s_csum_val), .s_csum_pos(s_csum_pos), .s_drop(s_drop),
		.s_corrupt(s_corrupt), .s_last(s_last), .s_valid(s_valid),
		.tx_data(tx_data), .tx_last(tx_last), .tx_fcs_active(tx_fcs_active),
		.tx_valid(tx_valid), .tx_ready(tx_ready), .tx_update_fcs(tx_update_fcs),
		.tx_csum_val(tx_csum_val), .tx_csum_pos(tx_csum_pos), .tx_corrupt(tx_corrupt)
	);

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return lo + r % (hi - lo + 1);
	endfunction

	// 0 holds tx_ready low, 1 high, 2 stalls about one cycle in four.
	task automatic next_cycle;
		@(negedge clk);
		case (ready_mode)
			0: tx_ready = 1'b0;
			1: tx_ready = 1'b1;
			default: tx_ready = (rand_range(0, 3) != 0);
		endcase
	endtask

	task automatic idle(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			next_cycle();
			s_valid = 1'b0;
			s_last  = 1'b0;
		end
	endtask

	// keep is set when the frame should find room in the DUT.
	task automatic send_frame(input int len, input logic drop, input logic keep,
			input int release_at);
		frame_exp_t fe;
		logic [7:0] b;
		int i;
		fe.len        = 8'(len);
		fe.fcs        = 1'($random(seed));
		fe.update_fcs = 1'($random(seed));
		fe.csum_val   = CSUM_W'($random(seed));
		fe.csum_pos   = CPOS_W'($random(seed));
		fe.corrupt    = 1'($random(seed));
		if (keep && !drop) begin
			exp_frames.push_back(fe);
		end
		for (i = 0; i < len; i++) begin
			next_cycle();
			b = 8'($random(seed));
			if (keep && !drop) begin
				exp_bytes.push_back(b);
			end
			s_valid      = 1'b1;
			s_data       = b;
			s_last       = (i == len - 1);
			s_fcs_active = fe.fcs;
			s_update_fcs = fe.update_fcs;
			s_csum_val   = fe.csum_val;
			s_csum_pos   = fe.csum_pos;
			s_drop       = drop;
			s_corrupt    = fe.corrupt;
			if (i == release_at) begin
				ready_mode = 1;
			end
		end
	endtask

	task automatic wait_drain;
		while (exp_frames.size() != 0) begin
			next_cycle();
		end
	endtask

	task automatic run_random(input int count, input int mode, input logic drops);
		int n;
		logic drop;
		ready_mode = mode;
		for (n = 0; n < count; n++) begin
			drop = drops && (rand_range(0, 2) == 0);
			send_frame(rand_range(1, MAX_LEN), drop, 1'b1, -1);
			idle(rand_range(3, MAX_GAP));
			wait_drain();
		end
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic check_beat;
		frame_exp_t fe;
		logic [7:0] eb;
		logic el;
		if (exp_frames.size() == 0 || exp_bytes.size() == 0) begin
			$display("error at %0t: a beat came out while no frame was expected", $time);
			errors++;
		end else begin
			fe = exp_frames[0];
			eb = exp_bytes.pop_front();
			el = (beat_idx == int'(fe.len) - 1);
			if (tx_data != eb) begin
				$display("MISMATCH at %0t: tx_data %h, expected %h", $time, tx_data, eb);
				errors++;
			end
			if (tx_last != el || tx_fcs_active != fe.fcs) begin
				$display("MISMATCH at %0t: last/fcs %b%b, expected %b%b", $time,
					tx_last, tx_fcs_active, el, fe.fcs);
				errors++;
			end
			if ({tx_update_fcs, tx_csum_val, tx_csum_pos, tx_corrupt} !=
					{fe.update_fcs, fe.csum_val, fe.csum_pos, fe.corrupt}) begin
				$display("MISMATCH at %0t: control fields %b %h %h %b, expected %b %h %h %b",
					$time, tx_update_fcs, tx_csum_val, tx_csum_pos, tx_corrupt,
					fe.update_fcs, fe.csum_val, fe.csum_pos, fe.corrupt);
				errors++;
			end
			if (el) begin
				exp_frames.delete(0);
				beat_idx = 0;
			end else begin
				beat_idx++;
			end
		end
	endtask

	// a stalled beat must hold until it moves.
	always @(posedge clk) begin
		if (rst_n) begin
			if (stalled && (!tx_valid || tx_data != held_data || tx_last != held_last)) begin
				$display("MISMATCH at %0t: stalled beat changed or vanished", $time);
				errors++;
			end
			if (tx_valid && tx_ready) begin
				check_beat();
			end
			stalled   = tx_valid & ~tx_ready;
			held_data = tx_data;
			held_last = tx_last;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		seed = 32'h2946_1f6e;
		ready_mode = 1;
		errors = 0;
		err_mark = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		cycle_cnt = 0;
		beat_idx = 0;
		stalled = 1'b0;
		held_data = 8'h00;
		held_last = 1'b0;
		s_data = 8'h00;
		s_fcs_active = 1'b0;
		s_update_fcs = 1'b0;
		s_csum_val = '0;
		s_csum_pos = '0;
		s_drop = 1'b0;
		s_corrupt = 1'b0;
		s_last = 1'b0;
		s_valid = 1'b0;
		tx_ready = 1'b0;
		while (!rst_n) begin
			next_cycle();
		end
		if (tx_valid) begin
			$display("error at %0t: tx_valid is high right after reset", $time);
			errors++;
		end

		run_random(NUM_FRAMES, 1, 1'b0);
		end_test("1 random frames");
		run_random(NUM_FRAMES, 2, 1'b0);
		end_test("2 random stalls");
		run_random(NUM_FRAMES, 2, 1'b1);
		end_test("3 dropped frames");

		// a 100-byte frame overflows the 64 entries before a normal frame follows.
		ready_mode = 0;
		idle(4);
		send_frame(100, 1'b0, 1'b0, -1);
		idle(70);
		send_frame(10, 1'b0, 1'b1, -1);
		idle(4);
		ready_mode = 1;
		wait_drain();
		end_test("4 overflow");

		// control FIFO fills after four frames.
		ready_mode = 0;
		for (int k = 0; k < 6; k++) begin
			send_frame(8, 1'b0, (k < `ETH_LOOP_CTL_DEPTH), -1);
			if (k < 5) begin
				idle(4);
			end
		end
		// room opens part-way through this frame, which starts with no gap.
		send_frame(MAX_LEN, 1'b0, 1'b0, 5);
		idle(4);
		wait_drain();
		// skipped frames would only show up behind the kept ones.
		idle(3 * MAX_LEN);
		end_test("5 control FIFO full");

		$display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, errors);
		if (fail_cnt == 0 && errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== eth_loop_top.f ====
+incdir+.
rtl/eth_loop_pkg.sv
rtl/axis_sync_fifo.sv
rtl/eth_frame_loop_fifo.sv
rtl/eth_loop_tx_gate.sv
rtl/eth_loop_top.sv
testbench/tb_clk_gen.sv
testbench/tb_eth_loop_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loopback buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_eth_loop_top \
	-f eth_loop_top.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
